//--- hawk_pkg.sv
// hawk shared definitions
// bus widths, table entry layouts and the cache-line union
// used by the bring-up write path and its testbench model
package hawk_pkg;

	// AXI write channel sizing
	localparam int AXI_ADDR_W = 64;
	localparam int AXI_DATA_W = 512; // one full cache line per beat
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// page numbers
	localparam int PPA_W = 48;

	// table geometry
	localparam int ATT_PER_LINE  = 8; // 64-bit entries
	localparam int LIST_PER_LINE = 4; // 128-bit entries
	localparam int LINE_BYTES    = 64; // address step per line

	// response codes on B
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	// one ATT slot, 64 bits
	typedef struct packed {
		logic [3:0]       sts;     // entry state
		logic [PPA_W-1:0] way;     // mapped page
		logic [11:0]      zpd_cnt; // zero page count
	} att_entry_t;

	// one free list node, 128 bits
	typedef struct packed {
		logic [15:0]      rsvd;
		logic [PPA_W-1:0] way;  // physical page held by the node
		logic [31:0]      prev; // 0 is NULL
		logic [31:0]      next; // 0 is NULL
	} list_entry_t;

	// a write data word seen as either table
	// entry 0 sits in the low bits of the line
	typedef union packed {
		logic [AXI_DATA_W-1:0]                raw;
		att_entry_t  [ATT_PER_LINE-1:0]       att;
		list_entry_t [LIST_PER_LINE-1:0]      list;
	} hawk_line_u;

endpackage

//--- hawk_ctrl.sv
// hawk control unit, bring-up mode only
// a start strobe runs ATT init and then list init,
// init_done is held once both tables are written
`timescale 1ns/1ps

module hawk_ctrl (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic start,     // one-cycle strobe
	input  logic att_done,  // from write manager
	input  logic list_done,
	output logic init_att,  // phase strobes to write manager
	output logic init_list,
	output logic init_done, // level until next start
	output logic err_clr    // clears sticky write error in the port
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ATT  = 2'd1;
	localparam logic [1:0] S_LIST = 2'd2;

	logic [1:0] state;

	// only an accepted start clears the error
	assign err_clr = start & (state == S_IDLE);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state     <= S_IDLE;
			init_att  <= 1'b0;
			init_list <= 1'b0;
			init_done <= 1'b0;
		end else begin
			init_att  <= 1'b0; // strobes last one cycle
			init_list <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						state     <= S_ATT;
						init_att  <= 1'b1;
						init_done <= 1'b0; // new sequence, drop done
					end
				end
				S_ATT: begin
					if (att_done) begin
						state     <= S_LIST;
						init_list <= 1'b1;
					end
				end
				S_LIST: begin
					if (list_done) begin
						state     <= S_IDLE;
						init_done <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- hawk_pgwr_mngr.sv
// page table write manager
// walks the ATT and list regions one cache line at a time,
// zero lines for ATT, one long doubly linked free list for the list table
`timescale 1ns/1ps

module hawk_pgwr_mngr import hawk_pkg::*; #(
	parameter logic [AXI_ADDR_W-1:0] ATT_BASE       = 64'h1000,
	parameter logic [AXI_ADDR_W-1:0] LIST_BASE      = 64'h8000,
	parameter logic [PPA_W-1:0]      PPA_START      = 48'h100,
	parameter int                    ATT_ENTRY_CNT  = 64,
	parameter int                    LIST_ENTRY_CNT = 32
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  init_att,   // phase strobes from ctrl
	input  logic                  init_list,
	input  logic                  port_busy,  // line in flight on AXI
	output logic                  line_vld,   // one-cycle strobe to the port
	output logic [AXI_ADDR_W-1:0] line_addr,
	output hawk_line_u            line_data,
	output logic                  att_done,   // one-cycle strobes back to ctrl
	output logic                  list_done
);

	localparam int ATT_LINES  = ATT_ENTRY_CNT / ATT_PER_LINE;
	localparam int LIST_LINES = LIST_ENTRY_CNT / LIST_PER_LINE;
	localparam int MAX_LINES  = (ATT_LINES > LIST_LINES) ? ATT_LINES : LIST_LINES;
	localparam int CNT_W      = $clog2(MAX_LINES + 1);

	localparam logic [31:0] LAST_ENT = 32'(LIST_ENTRY_CNT - 1); // tail of the free list

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ATT  = 2'd1;
	localparam logic [1:0] S_LIST = 2'd2;

	logic [1:0]       state;
	logic [CNT_W-1:0] lines_left; // lines still to issue after the current one
	logic [31:0]      ent_idx;    // first list entry of the next line
	logic             slot_free;  // port idle and no strobe this cycle
	logic             issue;
	logic             finish;

	// all-zero ATT line, built through the entry view
	function automatic hawk_line_u att_line();
		hawk_line_u ln;
		for (int i = 0; i < ATT_PER_LINE; i++) begin
			ln.att[i].sts     = '0; // invalid
			ln.att[i].way     = '0;
			ln.att[i].zpd_cnt = '0;
		end
		return ln;
	endfunction

	// four list nodes starting at entry number first
	function automatic hawk_line_u list_line(input logic [31:0] first);
		hawk_line_u  ln;
		logic [31:0] n;
		for (int i = 0; i < LIST_PER_LINE; i++) begin
			n                  = first + 32'(i);
			ln.list[i].rsvd    = '0;
			ln.list[i].way     = PPA_START + PPA_W'(n); // pages handed out in order
			ln.list[i].prev    = (n == 32'd0) ? 32'd0 : n - 32'd1; // head has NULL prev
			ln.list[i].next    = (n == LAST_ENT) ? 32'd0 : n + 32'd1; // tail has NULL next
		end
		return ln;
	endfunction

	assign slot_free = (state != S_IDLE) & ~line_vld & ~port_busy;
	assign issue     = slot_free & (lines_left != '0);
	assign finish    = slot_free & (lines_left == '0); // replaces the line after the last

	// control state
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= S_IDLE;
			line_vld   <= 1'b0;
			att_done   <= 1'b0;
			list_done  <= 1'b0;
			lines_left <= '0;
			ent_idx    <= '0;
		end else begin
			line_vld  <= 1'b0;
			att_done  <= 1'b0;
			list_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (init_att) begin
						state      <= S_ATT;
						line_vld   <= 1'b1; // first line right away
						lines_left <= CNT_W'(ATT_LINES - 1);
					end else if (init_list) begin
						state      <= S_LIST;
						line_vld   <= 1'b1;
						lines_left <= CNT_W'(LIST_LINES - 1);
						ent_idx    <= 32'(LIST_PER_LINE); // line 0 holds entries 0..3
					end
				end
				S_ATT, S_LIST: begin
					if (issue) begin
						line_vld   <= 1'b1;
						lines_left <= lines_left - 1'b1;
						if (state == S_LIST)
							ent_idx <= ent_idx + 32'(LIST_PER_LINE);
					end else if (finish) begin
						state     <= S_IDLE;
						att_done  <= (state == S_ATT);
						list_done <= (state == S_LIST);
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// line payload, loaded together with line_vld
	always_ff @(posedge clk_i) begin
		if (state == S_IDLE) begin
			if (init_att) begin
				line_addr <= ATT_BASE;
				line_data <= att_line();
			end else if (init_list) begin
				line_addr <= LIST_BASE;
				line_data <= list_line(32'd0);
			end
		end else if (issue) begin
			line_addr <= line_addr + AXI_ADDR_W'(LINE_BYTES); // next line in the region
			line_data <= (state == S_ATT) ? att_line() : list_line(ent_idx);
		end
	end

endmodule

//--- hawk_axi_wr_port.sv
// AXI4 write master, one full-line beat per transfer
// AW and W complete independently, B is always accepted
// and a non-OKAY response sets a sticky error
`timescale 1ns/1ps

module hawk_axi_wr_port import hawk_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  line_vld,  // strobe from write manager
	input  logic                  err_clr,
	input  logic [AXI_ADDR_W-1:0] line_addr,
	input  hawk_line_u            line_data,
	input  logic                  awready,
	input  logic                  wready,
	input  logic                  bvalid,
	input  logic [1:0]            bresp,
	output logic                  port_busy, // high until B is taken
	output logic                  awvalid,
	output logic                  wvalid,
	output logic                  bready,
	output logic                  wr_err,    // sticky
	output logic [AXI_ADDR_W-1:0] awaddr,
	output logic [AXI_DATA_W-1:0] wdata,
	output logic [AXI_STRB_W-1:0] wstrb
);

	logic b_take;

	assign bready = 1'b1;        // responses never stalled
	assign wstrb  = '1;          // bring-up lines are always full
	assign b_take = port_busy & bvalid;

	// channel valids and busy flag
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			port_busy <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
		end else begin
			if (line_vld) begin
				port_busy <= 1'b1;
				awvalid   <= 1'b1; // both channels rise together
				wvalid    <= 1'b1;
			end else begin
				if (awvalid && awready)
					awvalid <= 1'b0; // address accepted
				if (wvalid && wready)
					wvalid <= 1'b0;  // data accepted
				if (b_take)
					port_busy <= 1'b0;
			end
		end
	end

	// sticky error on bad response
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			wr_err <= 1'b0;
		else if (err_clr)
			wr_err <= 1'b0;
		else if (b_take && (bresp != AXI_RESP_OKAY))
			wr_err <= 1'b1;
	end

	// address and data held stable while the valids are up
	always_ff @(posedge clk_i) begin
		if (line_vld) begin
			awaddr <= line_addr;
			wdata  <= line_data.raw;
		end
	end

endmodule

//--- hawk_top.sv
// hawk bring-up subsystem
// control unit, page table write manager and AXI write port
`timescale 1ns/1ps

module hawk_top import hawk_pkg::*; #(
	parameter logic [AXI_ADDR_W-1:0] ATT_BASE       = 64'h1000,
	parameter logic [AXI_ADDR_W-1:0] LIST_BASE      = 64'h8000,
	parameter logic [PPA_W-1:0]      PPA_START      = 48'h100,
	parameter int                    ATT_ENTRY_CNT  = 64, // multiple of 8
	parameter int                    LIST_ENTRY_CNT = 32  // multiple of 4
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  start,
	output logic                  init_done,
	output logic                  wr_err,
	// AXI AW
	output logic [AXI_ADDR_W-1:0] awaddr,
	output logic                  awvalid,
	input  logic                  awready,
	// AXI W
	output logic [AXI_DATA_W-1:0] wdata,
	output logic [AXI_STRB_W-1:0] wstrb,
	output logic                  wvalid,
	input  logic                  wready,
	// AXI B
	input  logic [1:0]            bresp,
	input  logic                  bvalid,
	output logic                  bready
);

	logic                  init_att;  // ctrl to manager
	logic                  init_list;
	logic                  att_done;  // manager to ctrl
	logic                  list_done;
	logic                  err_clr;
	logic                  line_vld;  // manager to port
	logic [AXI_ADDR_W-1:0] line_addr;
	hawk_line_u            line_data;
	logic                  port_busy;

	hawk_ctrl u_ctrl (
		.clk_i(clk_i), .rst_ni(rst_ni), .start(start),
		.att_done(att_done), .list_done(list_done),
		.init_att(init_att), .init_list(init_list),
		.init_done(init_done), .err_clr(err_clr)
	);

	hawk_pgwr_mngr #(
		.ATT_BASE(ATT_BASE), .LIST_BASE(LIST_BASE), .PPA_START(PPA_START),
		.ATT_ENTRY_CNT(ATT_ENTRY_CNT), .LIST_ENTRY_CNT(LIST_ENTRY_CNT)
	) u_pgwr_mngr (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.init_att(init_att), .init_list(init_list), .port_busy(port_busy),
		.line_vld(line_vld), .line_addr(line_addr), .line_data(line_data),
		.att_done(att_done), .list_done(list_done)
	);

	hawk_axi_wr_port u_wr_port (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.line_vld(line_vld), .err_clr(err_clr),
		.line_addr(line_addr), .line_data(line_data),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.port_busy(port_busy), .awvalid(awvalid), .wvalid(wvalid),
		.bready(bready), .wr_err(wr_err),
		.awaddr(awaddr), .wdata(wdata), .wstrb(wstrb)
	);

endmodule

//--- tb_axi_mem.sv
// AXI slave memory for the hawk testbench
// random ready stalls and B delays, SLVERR at one chosen address,
// every write stored by address and logged in arrival order
`timescale 1ns/1ps

module tb_axi_mem import hawk_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [AXI_DATA_W-1:0] wdata,
	input  logic [AXI_STRB_W-1:0] wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic                  err_en,   // injection on or off
	input  logic [AXI_ADDR_W-1:0] err_addr  // line answered with SLVERR
);

	logic [AXI_DATA_W-1:0] mem [logic [AXI_ADDR_W-1:0]];
	logic [AXI_ADDR_W-1:0] log_addr [$]; // arrival order
	logic [AXI_STRB_W-1:0] log_strb [$];
	int unsigned           resp_cnt;     // B handshakes so far

	logic [AXI_ADDR_W-1:0] cur_addr;
	logic [AXI_DATA_W-1:0] cur_data;
	logic [AXI_STRB_W-1:0] cur_strb;
	logic                  aw_got, w_got, b_wait; // channel halves of the open write
	int unsigned           aw_stall, w_stall, b_dly;

	initial begin
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		bresp    = AXI_RESP_OKAY;
		resp_cnt = 0;
		cur_addr = '0;
		forever begin
			@(posedge clk_i); // handshakes sampled on the edge
			if (!rst_ni) begin
				aw_got   = 1'b0;
				w_got    = 1'b0;
				b_wait   = 1'b0;
				b_dly    = 0;
				aw_stall = $urandom_range(3, 0);
				w_stall  = $urandom_range(3, 0);
			end else begin
				if (awvalid && awready) begin
					cur_addr = awaddr;
					aw_got   = 1'b1;
					aw_stall = $urandom_range(3, 0); // stall for the next address
				end else if (awvalid && aw_stall != 0)
					aw_stall--;
				if (wvalid && wready) begin
					cur_data = wdata;
					cur_strb = wstrb;
					w_got    = 1'b1;
					w_stall  = $urandom_range(3, 0);
				end else if (wvalid && w_stall != 0)
					w_stall--;
				if (bvalid && bready) begin
					b_wait = 1'b0; // write closed
					aw_got = 1'b0;
					w_got  = 1'b0;
					resp_cnt++;
				end else if (aw_got && w_got && !b_wait) begin
					mem[cur_addr] = cur_data;
					log_addr.push_back(cur_addr);
					log_strb.push_back(cur_strb);
					b_wait = 1'b1;
					b_dly  = $urandom_range(3, 0); // response delay
				end else if (b_wait && b_dly != 0)
					b_dly--;
			end
			#1; // outputs move just after the edge
			awready = rst_ni && !aw_got && (aw_stall == 0);
			wready  = rst_ni && !w_got && (w_stall == 0);
			bvalid  = b_wait && (b_dly == 0);
			bresp   = (err_en && cur_addr == err_addr) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
		end
	end

endmodule

//--- tb_hawk.sv
// hawk bring-up testbench
// two runs against a stalling AXI memory, tables rebuilt from the init rules
// second run injects one SLVERR on a list line and fires a stray start
`timescale 1ns/1ps

module tb_hawk import hawk_pkg::*; ();

	localparam logic [AXI_ADDR_W-1:0] ATT_BASE  = 64'h1000;
	localparam logic [AXI_ADDR_W-1:0] LIST_BASE = 64'h8000;
	localparam logic [PPA_W-1:0]      PPA_START = 48'h100;
	localparam int ATT_CNT    = 64;
	localparam int LIST_CNT   = 32;
	localparam int ATT_LINES  = ATT_CNT / ATT_PER_LINE;
	localparam int LIST_LINES = LIST_CNT / LIST_PER_LINE;
	localparam int N_LINES    = ATT_LINES + LIST_LINES;
	localparam int WD_NS      = (N_LINES * 12 + 200) * 8 * 2; // two runs

	logic                  clk_i  = 1'b0;
	logic                  rst_ni = 1'b0;
	logic                  start  = 1'b0;
	logic                  init_done, wr_err;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid, awready, wvalid, wready, bvalid, bready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic [1:0]            bresp;
	logic                  err_en   = 1'b0;
	logic [AXI_ADDR_W-1:0] err_addr = '0;

	int                    errors = 0, stab_err = 0, stall_cycles = 0, n_pass = 0, n_fail = 0;
	logic                  held_aw = 1'b0, held_w = 1'b0; // valid without ready last cycle
	logic [AXI_ADDR_W-1:0] last_awaddr;
	logic [AXI_DATA_W-1:0] last_wdata;
	logic [AXI_STRB_W-1:0] last_wstrb;

	always #4 clk_i = ~clk_i;

	hawk_top #(
		.ATT_BASE(ATT_BASE), .LIST_BASE(LIST_BASE), .PPA_START(PPA_START),
		.ATT_ENTRY_CNT(ATT_CNT), .LIST_ENTRY_CNT(LIST_CNT)
	) dut0 (.*);

	tb_axi_mem u_mem (.*);

	// AW and W must hold still while stalled, checked mid-cycle
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (held_aw) begin
				stall_cycles++;
				if (!awvalid || awaddr != last_awaddr) begin
					$display("error stability: expected awaddr %h, actual %h (awvalid %b)",
						last_awaddr, awaddr, awvalid);
					stab_err++;
				end
			end
			if (held_w && (!wvalid || wdata != last_wdata || wstrb != last_wstrb)) begin
				$display("error stability: expected wdata %h, actual %h", last_wdata, wdata);
				stab_err++;
			end
			held_aw     = awvalid && !awready;
			held_w      = wvalid && !wready;
			last_awaddr = awaddr;
			last_wdata  = wdata;
			last_wstrb  = wstrb;
		end
	end

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			n_pass++;
			$display("test %s: ok", name);
		end else begin
			n_fail++;
			$display("test %s: failed, %0d errors", name, errs);
		end
	endtask

	// order and count from the memory log, contents read back by address
	task automatic check_tables(input int base);
		hawk_line_u            ln;
		list_entry_t           exp_ent;
		logic [AXI_ADDR_W-1:0] exp_addr;
		int                    cnt, mark, j, k, n;
		mark = errors;
		cnt  = u_mem.log_addr.size() - base;
		if (cnt != N_LINES) begin
			$display("error order_count: expected %0d writes, actual %0d", N_LINES, cnt);
			errors++;
		end
		for (j = 0; j < cnt && j < N_LINES; j++) begin
			exp_addr = (j < ATT_LINES) ? ATT_BASE + AXI_ADDR_W'(LINE_BYTES * j)
				: LIST_BASE + AXI_ADDR_W'(LINE_BYTES * (j - ATT_LINES)); // ATT first
			if (u_mem.log_addr[base + j] != exp_addr || u_mem.log_strb[base + j] != '1) begin
				$display("error order_count: expected %h/strb all ones, actual %h/strb %h",
					exp_addr, u_mem.log_addr[base + j], u_mem.log_strb[base + j]);
				errors++;
			end
		end
		report_test("order_count", errors - mark);
		mark = errors;
		for (j = 0; j < ATT_LINES; j++) begin
			ln.raw = u_mem.mem[ATT_BASE + AXI_ADDR_W'(LINE_BYTES * j)];
			for (k = 0; k < ATT_PER_LINE; k++)
				if (ln.att[k] != '0) begin
					$display("error att_contents: expected 0, actual %h", ln.att[k]);
					errors++;
				end
		end
		report_test("att_contents", errors - mark);
		mark = errors;
		for (j = 0; j < LIST_LINES; j++) begin
			ln.raw = u_mem.mem[LIST_BASE + AXI_ADDR_W'(LINE_BYTES * j)];
			for (k = 0; k < LIST_PER_LINE; k++) begin
				n            = j * LIST_PER_LINE + k; // entry number over the table
				exp_ent.rsvd = '0;
				exp_ent.way  = PPA_START + PPA_W'(n);
				exp_ent.prev = (n == 0) ? 32'd0 : 32'(n - 1);            // NULL at the head
				exp_ent.next = (n == LIST_CNT - 1) ? 32'd0 : 32'(n + 1); // NULL at the tail
				if (ln.list[k] != exp_ent) begin
					$display("error list_contents: expected %h, actual %h", exp_ent, ln.list[k]);
					errors++;
				end
			end
		end
		report_test("list_contents", errors - mark);
	endtask

	// one bring-up, inject also fires a stray start once the error shows
	task automatic run_bringup(input logic inject, input string name);
		int   log_base, resp_base, mark;
		logic stray;
		mark      = errors;
		log_base  = u_mem.log_addr.size();
		resp_base = int'(u_mem.resp_cnt);
		stray     = 1'b0;
		err_en    = inject;
		err_addr  = LIST_BASE + AXI_ADDR_W'(LINE_BYTES * $urandom_range(LIST_LINES - 1, 0));
		@(posedge clk_i);
		#1 start = 1'b1;
		@(posedge clk_i);
		#1 start = 1'b0; // init_done already dropped here
		while (!init_done) begin
			@(posedge clk_i);
			#1 start = inject && wr_err && !stray; // list phase, must be ignored
			stray    = stray || start;
		end
		if (int'(u_mem.resp_cnt) - resp_base != N_LINES) begin
			$display("error %s: expected %0d B responses at init_done, actual %0d", name,
				N_LINES, int'(u_mem.resp_cnt) - resp_base);
			errors++;
		end
		if (wr_err !== inject) begin
			$display("error %s: expected wr_err %b, actual %b", name, inject, wr_err);
			errors++;
		end
		report_test(name, errors - mark);
		repeat (30) @(posedge clk_i); // a wrongly taken start would write more lines
		check_tables(log_base);
	endtask

	initial begin
		#(WD_NS);
		$display("timeout: bring-up did not finish within %0d ns", WD_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(84));
		repeat (2) @(posedge clk_i);
		#1 rst_ni = 1'b1;
		run_bringup(1'b0, "completion");
		run_bringup(1'b1, "error_inject");
		errors += stab_err;
		report_test("stability", stab_err);
		$display("summary: %0d tests passed, %0d failed, %0d errors, %0d stall cycles checked",
			n_pass, n_fail, errors, stall_cycles);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
hawk_pkg.sv
hawk_ctrl.sv
hawk_pgwr_mngr.sv
hawk_axi_wr_port.sv
hawk_top.sv
tb_axi_mem.sv
tb_hawk.sv

//--- Makefile
# Verilator build and run of the hawk bring-up testbench
VERILATOR ?= verilator
TOP       ?= tb_hawk
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
